/* run_sim.sh */
#!/usr/bin/env bash
# compile the XR subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module xr_tb -f sim.f -o xr_tb_sim \
    || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/xr_tb_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+verilog
+incdir+verif
verilog/xr_pkg.sv
verilog/xr_dpram.sv
verilog/xr_regs.sv
verilog/xrmem_arb.sv
verilog/xr_subsys_top.sv
verif/xr_tb.sv

/* verif/xr_tb_tasks.svh */
// XR testbench tasks

task automatic check_word(input string what, input xr_pkg::word_t got,
                          input xr_pkg::word_t exp);
    assert (got === exp) else begin
        err_count++;
        $display("Error: %0d ns: %s got %h, expected %h", $time, what, got, exp);
        $display("TEST FAIL");
        $fatal(1, "stopping at first mismatch");
    end
endtask

// read data is taken in the ack cycle, select drops on the next edge
task automatic wait_ack(output xr_pkg::word_t data);
    do begin
        @(negedge clk);
    end while (!xr_ack_o);
    data = xr_data_o;
    @(posedge clk);
    xr_sel_i <= 1'b0;
    xr_wr_i  <= 1'b0;
endtask

task automatic host_write(input xr_pkg::addr_t addr, input xr_pkg::word_t data);
    xr_pkg::word_t ack_data;
    @(posedge clk);
    xr_sel_i  <= 1'b1;
    xr_wr_i   <= 1'b1;
    xr_addr_i <= addr;
    xr_data_i <= data;
    wait_ack(ack_data);
endtask

task automatic host_read(input xr_pkg::addr_t addr, output xr_pkg::word_t data);
    @(posedge clk);
    xr_sel_i  <= 1'b1;
    xr_wr_i   <= 1'b0;
    xr_addr_i <= addr;
    wait_ack(data);
endtask

task automatic vid_color_read(input xr_pkg::color_addr_t idx,
                              output xr_pkg::word_t a_data, output xr_pkg::word_t b_data);
    @(posedge clk);
    vgen_color_sel_i    <= 1'b1;
    vgen_color_a_addr_i <= idx;
    vgen_color_b_addr_i <= idx;
    @(posedge clk);
    vgen_color_sel_i <= 1'b0;
    @(negedge clk);
    a_data = vgen_color_a_data_o;
    b_data = vgen_color_b_data_o;
endtask

task automatic vid_tile_read(input xr_pkg::tile_addr_t addr, output xr_pkg::word_t data);
    @(posedge clk);
    vgen_tile_sel_i  <= 1'b1;
    vgen_tile_addr_i <= addr;
    @(posedge clk);
    vgen_tile_sel_i <= 1'b0;
    @(negedge clk);
    data = vgen_tile_data_o;
endtask

task automatic reset_values();
    xr_pkg::word_t data;
    repeat (4) begin
        @(negedge clk);
        check_word("ack while idle", {15'd0, xr_ack_o}, '0);
    end
    for (int i = 0; i < `XR_REG_COUNT; i++) begin
        reg_model[i] = '0;
        host_read(xr_pkg::addr_t'(i), data);
        check_word($sformatf("register %0d after reset", i), data, '0);
    end
endtask

task automatic register_rw();
    xr_pkg::word_t data;
    for (int i = 0; i < `XR_REG_COUNT; i++) begin
        reg_model[i] = xr_pkg::word_t'($urandom);
        host_write(xr_pkg::addr_t'(i), reg_model[i]);
    end
    for (int i = 0; i < `XR_REG_COUNT; i++) begin
        host_read(xr_pkg::addr_t'(i), data);
        check_word($sformatf("register %0d", i), data, reg_model[i]);
    end
    check_word("vid_ctrl_o", vid_ctrl_o, reg_model[0]);
    // index 40 lies past the implemented registers
    host_write(16'h0028, ~reg_model[8]);
    host_read(16'h0028, data);
    check_word("register 40", data, '0);
    host_read(16'h0008, data);
    check_word("register 8 after write to 40", data, reg_model[8]);
endtask

task automatic color_rw();
    xr_pkg::color_addr_t idx;
    xr_pkg::word_t a_val;
    xr_pkg::word_t b_val;
    xr_pkg::word_t a_data;
    xr_pkg::word_t b_data;
    for (int i = 0; i < 8; i++) begin
        idx = xr_pkg::color_addr_t'(i * 37 + 3);
        a_val = xr_pkg::word_t'($urandom);
        // bank B differs from bank A in bit 15 at least
        b_val = {~a_val[15], 15'($urandom)};
        color_idx.push_back(idx);
        color_a_model[int'(idx)] = a_val;
        color_b_model[int'(idx)] = b_val;
        host_write({8'h40, idx}, a_val);
        host_write({8'h41, idx}, b_val);
    end
    foreach (color_idx[n]) begin
        idx = color_idx[n];
        host_read({8'h40, idx}, a_data);
        check_word($sformatf("host color A %0d", idx), a_data, color_a_model[int'(idx)]);
        host_read({8'h41, idx}, b_data);
        check_word($sformatf("host color B %0d", idx), b_data, color_b_model[int'(idx)]);
        vid_color_read(idx, a_data, b_data);
        check_word($sformatf("video color A %0d", idx), a_data, color_a_model[int'(idx)]);
        check_word($sformatf("video color B %0d", idx), b_data, color_b_model[int'(idx)]);
    end
endtask

task automatic tile_rw();
    xr_pkg::tile_addr_t t;
    xr_pkg::word_t data;
    // alternate between the main bank and the second bank
    for (int i = 0; i < 8; i++) begin
        tile_addrs.push_back(xr_pkg::tile_addr_t'(i * 211 + 3));
        tile_addrs.push_back(xr_pkg::tile_addr_t'(12'h800 + i * 61 + 2));
    end
    foreach (tile_addrs[n]) begin
        t = tile_addrs[n];
        tile_model[int'(t)] = xr_pkg::word_t'($urandom);
        host_write({4'h8, t}, tile_model[int'(t)]);
    end
    foreach (tile_addrs[n]) begin
        t = tile_addrs[n];
        host_read({4'h8, t}, data);
        check_word($sformatf("host tile %h", t), data, tile_model[int'(t)]);
        vid_tile_read(t, data);
        check_word($sformatf("video tile %h", t), data, tile_model[int'(t)]);
    end
endtask

task automatic video_contention();
    xr_pkg::color_addr_t idx;
    xr_pkg::word_t data;
    // video holds the tile read port, the host read has to wait
    @(posedge clk);
    vgen_tile_sel_i  <= 1'b1;
    vgen_tile_addr_i <= tile_addrs[0];
    xr_sel_i         <= 1'b1;
    xr_wr_i          <= 1'b0;
    xr_addr_i        <= {4'h8, tile_addrs[1]};
    repeat (6) begin
        @(negedge clk);
        check_word("ack during video tile reads", {15'd0, xr_ack_o}, '0);
    end
    @(posedge clk);
    vgen_tile_sel_i <= 1'b0;
    wait_ack(data);
    check_word("tile read after contention", data, tile_model[int'(tile_addrs[1])]);

    // host color write in the middle of a video read burst
    idx = color_idx[0];
    color_a_model[int'(idx)] = xr_pkg::word_t'($urandom);
    fork
        begin
            @(posedge clk);
            vgen_color_sel_i <= 1'b1;
            repeat (12) begin
                vgen_color_a_addr_i <= xr_pkg::color_addr_t'($urandom);
                vgen_color_b_addr_i <= xr_pkg::color_addr_t'($urandom);
                @(posedge clk);
            end
            vgen_color_sel_i <= 1'b0;
        end
        begin
            host_write({8'h40, idx}, color_a_model[int'(idx)]);
            // the write acks while the video burst is still running
            check_word("video still reading at write ack", {15'd0, vgen_color_sel_i}, 16'd1);
        end
    join
    host_read({8'h40, idx}, data);
    check_word("color write under video reads", data, color_a_model[int'(idx)]);
endtask

task automatic reserved_region();
    xr_pkg::word_t data;
    host_read(16'hc003, data);
    check_word("reserved region read", data, '0);
    // low bits alias register 3, color index 3 and tile 3
    host_write(16'hc003, ~reg_model[3]);
    host_read(16'hc003, data);
    check_word("reserved region read after write", data, '0);
    host_read(16'h0003, data);
    check_word("register 3 after reserved write", data, reg_model[3]);
    host_read(16'h4003, data);
    check_word("color A 3 after reserved write", data, color_a_model[3]);
    host_read({4'h8, tile_addrs[0]}, data);
    check_word("tile after reserved write", data, tile_model[int'(tile_addrs[0])]);
endtask

/* verif/xr_tb.sv */
// XR subsystem testbench
`default_nettype none

`include "xr_settings.svh"

module xr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    // rough count of host and video accesses over all tests
    localparam int ACCESS_COUNT = 200;
    localparam int CYCLES_PER_ACCESS = 20;

    logic                   clk;
    logic                   arst_n_i;
    logic                   xr_sel_i;
    logic                   xr_wr_i;
    xr_pkg::addr_t          xr_addr_i;
    xr_pkg::word_t          xr_data_i;
    logic                   xr_ack_o;
    xr_pkg::word_t          xr_data_o;
    logic                   vgen_color_sel_i;
    xr_pkg::color_addr_t    vgen_color_a_addr_i;
    xr_pkg::color_addr_t    vgen_color_b_addr_i;
    xr_pkg::argb_t          vgen_color_a_data_o;
    xr_pkg::argb_t          vgen_color_b_data_o;
    logic                   vgen_tile_sel_i;
    xr_pkg::tile_addr_t     vgen_tile_addr_i;
    xr_pkg::word_t          vgen_tile_data_o;
    xr_pkg::word_t          vid_ctrl_o;

    int                     err_count;

    // reference model of everything written so far
    xr_pkg::word_t          reg_model [int];
    xr_pkg::word_t          color_a_model [int];
    xr_pkg::word_t          color_b_model [int];
    xr_pkg::word_t          tile_model [int];
    xr_pkg::color_addr_t    color_idx [$];
    xr_pkg::tile_addr_t     tile_addrs [$];

    xr_subsys_top dut (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .xr_sel_i            (xr_sel_i),
        .xr_wr_i             (xr_wr_i),
        .xr_addr_i           (xr_addr_i),
        .xr_data_i           (xr_data_i),
        .xr_ack_o            (xr_ack_o),
        .xr_data_o           (xr_data_o),
        .vgen_color_sel_i    (vgen_color_sel_i),
        .vgen_color_a_addr_i (vgen_color_a_addr_i),
        .vgen_color_b_addr_i (vgen_color_b_addr_i),
        .vgen_color_a_data_o (vgen_color_a_data_o),
        .vgen_color_b_data_o (vgen_color_b_data_o),
        .vgen_tile_sel_i     (vgen_tile_sel_i),
        .vgen_tile_addr_i    (vgen_tile_addr_i),
        .vgen_tile_data_o    (vgen_tile_data_o),
        .vid_ctrl_o          (vid_ctrl_o)
    );

    `include "xr_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(ACCESS_COUNT * CYCLES_PER_ACCESS * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $fatal(1, "simulation timed out");
    end

    initial begin
        void'($urandom(32'h6be7));
        err_count = 0;
        arst_n_i            <= 1'b0;
        xr_sel_i            <= 1'b0;
        xr_wr_i             <= 1'b0;
        xr_addr_i           <= '0;
        xr_data_i           <= '0;
        vgen_color_sel_i    <= 1'b0;
        vgen_color_a_addr_i <= '0;
        vgen_color_b_addr_i <= '0;
        vgen_tile_sel_i     <= 1'b0;
        vgen_tile_addr_i    <= '0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        reset_values();
        register_rw();
        color_rw();
        tile_rw();
        video_contention();
        reserved_region();
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/xr_dpram.sv */
// Simple dual port RAM
`default_nettype none

module xr_dpram #(
    parameter int AWIDTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   wr_en_i,
    input  wire logic [AWIDTH-1:0]      wr_addr_i,
    input  wire xr_pkg::word_t          wr_data_i,
    input  wire logic                   rd_en_i,
    input  wire logic [AWIDTH-1:0]      rd_addr_i,
    output      xr_pkg::word_t          rd_data_o
);

    localparam int DEPTH = 1 << AWIDTH;

    xr_pkg::word_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, output holds between enabled reads
    // a read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* verilog/xr_pkg.sv */
// XR bus and memory types
`default_nettype none

`include "xr_settings.svh"

package xr_pkg;

    // host XR bus address, region in bits 15:14
    typedef logic [15:0] addr_t;

    // data word on every XR path
    typedef logic [15:0] word_t;

    // index into one color lookup bank
    typedef logic [`XR_COLOR_W-1:0] color_addr_t;

    // color lookup entry, 4 bits each of alpha, red, green, blue
    typedef logic [15:0] argb_t;

    // tile memory address across both tile banks
    typedef logic [`XR_TILE_W-1:0] tile_addr_t;

    // register bus address
    typedef logic [6:0] reg_addr_t;

endpackage

`default_nettype wire

/* verilog/xr_regs.sv */
// XR configuration registers
`default_nettype none

`include "xr_settings.svh"

module xr_regs (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire logic                   xreg_wr_i,
    input  wire xr_pkg::reg_addr_t      xreg_addr_i,
    input  wire xr_pkg::word_t          xreg_data_i,
    output      xr_pkg::word_t          xreg_data_o,
    output      xr_pkg::word_t          vid_ctrl_o
);

    localparam int IDX_W = $clog2(`XR_REG_COUNT);
    localparam xr_pkg::reg_addr_t REG_LIMIT = xr_pkg::reg_addr_t'(`XR_REG_COUNT);

    xr_pkg::word_t      regs [`XR_REG_COUNT];
    logic [IDX_W-1:0]   reg_idx;
    logic               in_range;

    assign reg_idx  = xreg_addr_i[IDX_W-1:0];
    assign in_range = (xreg_addr_i < REG_LIMIT);

    // register file, writes outside the implemented range are dropped
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `XR_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (xreg_wr_i && in_range) begin
            regs[reg_idx] <= xreg_data_i;
        end
    end

    // combinational read back to the arbiter
    always_comb begin
        xreg_data_o = '0;
        if (in_range) begin
            xreg_data_o = regs[reg_idx];
        end
    end

    // register 0 drives the video control outputs
    assign vid_ctrl_o = regs[0];

    // a write is visible in the register one cycle later
    property p_write_lands;
        @(posedge clk) disable iff (!arst_n_i)
        (xreg_wr_i && in_range) |=> (regs[$past(reg_idx)] == $past(xreg_data_i));
    endproperty

    a_write_lands: assert property (p_write_lands)
        else $error("xr_regs: write did not reach register");

endmodule

`default_nettype wire

/* verilog/xr_settings.svh */
// XR memory subsystem sizes
`ifndef XR_SETTINGS_SVH
`define XR_SETTINGS_SVH

// configuration registers backed by flops
// anything at or above this index reads as zero
`define XR_REG_COUNT    16

// color lookup address width
// 256 entries in each playfield bank
`define XR_COLOR_W      8

// full tile address width
// the top bit picks the second tile bank
`define XR_TILE_W       12

// second tile bank address width
// 512 words, so only the low bits of a tile address are used there
`define XR_TILE2_W      9

`endif

/* verilog/xr_subsys_top.sv */
// XR memory subsystem top
`default_nettype none

module xr_subsys_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,

    // host XR bus
    input  wire logic                   xr_sel_i,
    input  wire logic                   xr_wr_i,
    input  wire xr_pkg::addr_t          xr_addr_i,
    input  wire xr_pkg::word_t          xr_data_i,
    output      logic                   xr_ack_o,
    output      xr_pkg::word_t          xr_data_o,

    // video read ports
    input  wire logic                   vgen_color_sel_i,
    input  wire xr_pkg::color_addr_t    vgen_color_a_addr_i,
    input  wire xr_pkg::color_addr_t    vgen_color_b_addr_i,
    output      xr_pkg::argb_t          vgen_color_a_data_o,
    output      xr_pkg::argb_t          vgen_color_b_data_o,
    input  wire logic                   vgen_tile_sel_i,
    input  wire xr_pkg::tile_addr_t     vgen_tile_addr_i,
    output      xr_pkg::word_t          vgen_tile_data_o,

    output      xr_pkg::word_t          vid_ctrl_o
);

    logic                   xreg_wr;
    xr_pkg::reg_addr_t      xreg_addr;
    xr_pkg::word_t          xreg_wr_data;
    xr_pkg::word_t          xreg_rd_data;

    xrmem_arb u_arb (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .xr_sel_i            (xr_sel_i),
        .xr_wr_i             (xr_wr_i),
        .xr_addr_i           (xr_addr_i),
        .xr_data_i           (xr_data_i),
        .xr_ack_o            (xr_ack_o),
        .xr_data_o           (xr_data_o),
        .xreg_wr_o           (xreg_wr),
        .xreg_addr_o         (xreg_addr),
        .xreg_data_i         (xreg_rd_data),
        .xreg_data_o         (xreg_wr_data),
        .vgen_color_sel_i    (vgen_color_sel_i),
        .vgen_color_a_addr_i (vgen_color_a_addr_i),
        .vgen_color_b_addr_i (vgen_color_b_addr_i),
        .vgen_color_a_data_o (vgen_color_a_data_o),
        .vgen_color_b_data_o (vgen_color_b_data_o),
        .vgen_tile_sel_i     (vgen_tile_sel_i),
        .vgen_tile_addr_i    (vgen_tile_addr_i),
        .vgen_tile_data_o    (vgen_tile_data_o)
    );

    // config registers, read and written over the register bus
    xr_regs u_regs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .xreg_wr_i   (xreg_wr),
        .xreg_addr_i (xreg_addr),
        .xreg_data_i (xreg_wr_data),
        .xreg_data_o (xreg_rd_data),
        .vid_ctrl_o  (vid_ctrl_o)
    );

endmodule

`default_nettype wire

/* verilog/xrmem_arb.sv */
// XR memory arbiter
`default_nettype none

`include "xr_settings.svh"

module xrmem_arb (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,

    // host XR bus
    input  wire logic                   xr_sel_i,
    input  wire logic                   xr_wr_i,
    input  wire xr_pkg::addr_t          xr_addr_i,
    input  wire xr_pkg::word_t          xr_data_i,
    output      logic                   xr_ack_o,
    output      xr_pkg::word_t          xr_data_o,

    // register bus to xr_regs
    output      logic                   xreg_wr_o,
    output      xr_pkg::reg_addr_t      xreg_addr_o,
    input  wire xr_pkg::word_t          xreg_data_i,
    output      xr_pkg::word_t          xreg_data_o,

    // video color reads
    input  wire logic                   vgen_color_sel_i,
    input  wire xr_pkg::color_addr_t    vgen_color_a_addr_i,
    input  wire xr_pkg::color_addr_t    vgen_color_b_addr_i,
    output      xr_pkg::argb_t          vgen_color_a_data_o,
    output      xr_pkg::argb_t          vgen_color_b_data_o,

    // video tile reads
    input  wire logic                   vgen_tile_sel_i,
    input  wire xr_pkg::tile_addr_t     vgen_tile_addr_i,
    output      xr_pkg::word_t          vgen_tile_data_o
);

    // region codes in address bits 15:14
    localparam logic [1:0] REGION_REGS  = 2'b00;
    localparam logic [1:0] REGION_COLOR = 2'b01;
    localparam logic [1:0] REGION_TILE  = 2'b10;
    localparam logic [1:0] REGION_RSVD  = 2'b11;

    logic                   host_req;
    logic                   regs_sel;
    logic                   color_sel;
    logic                   tile_sel;
    logic                   rsvd_sel;

    logic                   wr_ack_next;
    logic                   reg_rd_ack_next;
    logic                   color_rd_ack_next;
    logic                   tile_rd_ack_next;
    logic                   rsvd_rd_ack_next;

    logic                   color_rd_en;
    xr_pkg::color_addr_t    color_a_rd_addr;
    xr_pkg::color_addr_t    color_b_rd_addr;
    xr_pkg::word_t          color_a_rd_data;
    xr_pkg::word_t          color_b_rd_data;

    logic                   tile_rd_en;
    xr_pkg::tile_addr_t     tile_rd_addr;
    logic                   tile_bank_q;
    xr_pkg::word_t          tile_main_rd_data;
    xr_pkg::word_t          tile2_rd_data;
    xr_pkg::word_t          tile_rd_data;

    // an access is only considered while its ack is not yet out
    assign host_req  = xr_sel_i & ~xr_ack_o;

    assign regs_sel  = (xr_addr_i[15:14] == REGION_REGS);
    assign color_sel = (xr_addr_i[15:14] == REGION_COLOR);
    assign tile_sel  = (xr_addr_i[15:14] == REGION_TILE);
    assign rsvd_sel  = (xr_addr_i[15:14] == REGION_RSVD);

    // writes use the write ports only, so video never blocks them
    // a reserved region write is acked and dropped
    assign wr_ack_next       = host_req & xr_wr_i;
    assign reg_rd_ack_next   = host_req & ~xr_wr_i & regs_sel;
    assign color_rd_ack_next = host_req & ~xr_wr_i & color_sel & ~vgen_color_sel_i;
    assign tile_rd_ack_next  = host_req & ~xr_wr_i & tile_sel & ~vgen_tile_sel_i;
    assign rsvd_rd_ack_next  = host_req & ~xr_wr_i & rsvd_sel;

    // register bus
    assign xreg_wr_o   = wr_ack_next & regs_sel;
    assign xreg_addr_o = xr_addr_i[6:0];
    assign xreg_data_o = xr_data_i;

    // color read port, video wins when it asks
    assign color_rd_en     = vgen_color_sel_i | color_rd_ack_next;
    assign color_a_rd_addr = vgen_color_sel_i ? vgen_color_a_addr_i
                                              : xr_addr_i[`XR_COLOR_W-1:0];
    assign color_b_rd_addr = vgen_color_sel_i ? vgen_color_b_addr_i
                                              : xr_addr_i[`XR_COLOR_W-1:0];

    // tile read port, same priority
    assign tile_rd_en   = vgen_tile_sel_i | tile_rd_ack_next;
    assign tile_rd_addr = vgen_tile_sel_i ? vgen_tile_addr_i : xr_addr_i[`XR_TILE_W-1:0];

    // bank of the last tile read picks which RAM output is live
    assign tile_rd_data = tile_bank_q ? tile2_rd_data : tile_main_rd_data;

    assign vgen_color_a_data_o = color_a_rd_data;
    assign vgen_color_b_data_o = color_b_rd_data;
    assign vgen_tile_data_o    = tile_rd_data;

    // host read data, valid in the ack cycle since the address is held
    always_comb begin
        xr_data_o = '0;
        if (regs_sel) begin
            xr_data_o = xreg_data_i;
        end else if (color_sel) begin
            xr_data_o = xr_addr_i[`XR_COLOR_W] ? color_b_rd_data : color_a_rd_data;
        end else if (tile_sel) begin
            xr_data_o = tile_rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xr_ack_o    <= 1'b0;
            tile_bank_q <= 1'b0;
        end else begin
            xr_ack_o <= wr_ack_next | reg_rd_ack_next | color_rd_ack_next
                        | tile_rd_ack_next | rsvd_rd_ack_next;
            if (tile_rd_en) begin
                tile_bank_q <= tile_rd_addr[`XR_TILE_W-1];
            end
        end
    end

    // playfield A colors
    xr_dpram #(.AWIDTH(`XR_COLOR_W)) u_color_a (
        .clk       (clk),
        .wr_en_i   (wr_ack_next & color_sel & ~xr_addr_i[`XR_COLOR_W]),
        .wr_addr_i (xr_addr_i[`XR_COLOR_W-1:0]),
        .wr_data_i (xr_data_i),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_a_rd_addr),
        .rd_data_o (color_a_rd_data)
    );

    // playfield B colors
    xr_dpram #(.AWIDTH(`XR_COLOR_W)) u_color_b (
        .clk       (clk),
        .wr_en_i   (wr_ack_next & color_sel & xr_addr_i[`XR_COLOR_W]),
        .wr_addr_i (xr_addr_i[`XR_COLOR_W-1:0]),
        .wr_data_i (xr_data_i),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_b_rd_addr),
        .rd_data_o (color_b_rd_data)
    );

    // main tile bank, lower half of the tile space
    xr_dpram #(.AWIDTH(`XR_TILE_W-1)) u_tile_main (
        .clk       (clk),
        .wr_en_i   (wr_ack_next & tile_sel & ~xr_addr_i[`XR_TILE_W-1]),
        .wr_addr_i (xr_addr_i[`XR_TILE_W-2:0]),
        .wr_data_i (xr_data_i),
        .rd_en_i   (tile_rd_en & ~tile_rd_addr[`XR_TILE_W-1]),
        .rd_addr_i (tile_rd_addr[`XR_TILE_W-2:0]),
        .rd_data_o (tile_main_rd_data)
    );

    // second tile bank, mirrors through the upper half
    xr_dpram #(.AWIDTH(`XR_TILE2_W)) u_tile2 (
        .clk       (clk),
        .wr_en_i   (wr_ack_next & tile_sel & xr_addr_i[`XR_TILE_W-1]),
        .wr_addr_i (xr_addr_i[`XR_TILE2_W-1:0]),
        .wr_data_i (xr_data_i),
        .rd_en_i   (tile_rd_en & tile_rd_addr[`XR_TILE_W-1]),
        .rd_addr_i (tile_rd_addr[`XR_TILE2_W-1:0]),
        .rd_data_o (tile2_rd_data)
    );

    // ack is a single cycle pulse
    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n_i) xr_ack_o |=> !xr_ack_o)
        else $error("xrmem_arb: ack held for two cycles");

    // ack answers a request seen on the previous edge
    a_ack_needs_sel: assert property (
        @(posedge clk) disable iff (!arst_n_i) xr_ack_o |-> $past(xr_sel_i))
        else $error("xrmem_arb: ack without a prior select");

endmodule

`default_nettype wire
